// ==== design/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic [4:0] shamt;
        funct_e   funct;
    } instr_r_t;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        logic [15:0] imm;
    } instr_i_t;

    // same word, two field layouts
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    typedef struct packed {
        logic    valid;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        alu_op_e alu_op;
    } ex_ctrl_t;

    typedef struct packed {
        ex_ctrl_t ctrl;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dest;
        word_t    operand_a;
        word_t    operand_b;
        word_t    store_data;
    } id_ex_t;

    typedef struct packed {
        ex_ctrl_t ctrl;
        reg_idx_t dest;
        word_t    alu_result;
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        reg_idx_t dest;
        word_t    alu_result;
        word_t    read_data;
    } mem_wb_t;

    typedef struct packed {
        logic       we;
        logic [9:0] addr;
        word_t      data;
    } prog_write_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        word_t    data;
    } wb_trace_t;

endpackage

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic     clk,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  logic     wb_write,
    input  reg_idx_t wb_idx,
    input  word_t    wb_data,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (wb_write && wb_idx != '0) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rs_data = (rs == '0) ? '0 :
                     (wb_write && wb_idx == rs) ? wb_data : regs[rs];
    assign rt_data = (rt == '0) ? '0 :
                     (wb_write && wb_idx == rt) ? wb_data : regs[rt];

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import cpu_pkg::*; #(
    parameter int IMEM_ADDR_W = 10
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    input  prog_write_t prog,
    input  logic        stall,
    input  logic        redirect,
    input  word_t       target,
    output word_t       if_pc,
    output instr_u      if_instr,
    output logic        if_valid
);

    word_t imem [2**IMEM_ADDR_W];
    word_t pc;
    word_t fetch_word;

    // loader only gets the memory while the core is held
    always_ff @(posedge clk) begin
        if (prog.we && !run) begin
            imem[prog.addr[IMEM_ADDR_W-1:0]] <= prog.data;
        end
    end

    assign fetch_word = imem[pc[IMEM_ADDR_W+1:2]];

    always_ff @(posedge clk) begin
        if (run && !stall) begin
            if_pc    <= pc;
            if_instr <= fetch_word;
        end

        if (!rst_n || !run) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (redirect) begin
            // word fetched behind a taken branch is dropped
            pc       <= target;
            if_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc + 32'd4;
            if_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/decode_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_unit import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     run,
    input  logic     stall,
    input  word_t    if_pc,
    input  instr_u   if_instr,
    input  logic     if_valid,
    input  logic     wb_write,
    input  reg_idx_t wb_idx,
    input  word_t    wb_data,
    output reg_idx_t id_rs,
    output reg_idx_t id_rt,
    output logic     id_branch,
    output logic     id_uses_rt,
    output logic     redirect,
    output word_t    target,
    output id_ex_t   id_ex
);

    word_t    rs_data;
    word_t    rt_data;
    word_t    imm_ext;
    ex_ctrl_t dec_ctrl;
    reg_idx_t dest;
    logic     use_imm;
    logic     is_beq;
    logic     rt_read;

    register_file u_regs (
        .clk     (clk),
        .rs      (if_instr.i.rs),
        .rt      (if_instr.i.rt),
        .wb_write(wb_write),
        .wb_idx  (wb_idx),
        .wb_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    assign imm_ext = {{16{if_instr.i.imm[15]}}, if_instr.i.imm};

    always_comb begin
        dec_ctrl       = '0;
        dec_ctrl.valid = 1'b1;
        dest           = if_instr.r.rd;
        use_imm        = 1'b0;
        is_beq         = 1'b0;
        rt_read        = 1'b0;

        case (if_instr.r.opcode)
            op_rtype: begin
                rt_read            = 1'b1;
                dec_ctrl.reg_write = 1'b1;
                case (if_instr.r.funct)
                    fn_add:  dec_ctrl.alu_op = alu_add;
                    fn_sub:  dec_ctrl.alu_op = alu_sub;
                    fn_and:  dec_ctrl.alu_op = alu_and;
                    fn_or:   dec_ctrl.alu_op = alu_or;
                    fn_slt:  dec_ctrl.alu_op = alu_slt;
                    default: dec_ctrl.reg_write = 1'b0;
                endcase
            end
            op_addi: begin
                dec_ctrl.reg_write = 1'b1;
                use_imm            = 1'b1;
                dest               = if_instr.i.rt;
            end
            op_lw: begin
                dec_ctrl.reg_write = 1'b1;
                dec_ctrl.mem_read  = 1'b1;
                use_imm            = 1'b1;
                dest               = if_instr.i.rt;
            end
            op_sw: begin
                dec_ctrl.mem_write = 1'b1;
                use_imm            = 1'b1;
                rt_read            = 1'b1;
            end
            op_beq: begin
                is_beq  = 1'b1;
                rt_read = 1'b1;
            end
            default: ;
        endcase

        if (dest == '0) begin
            dec_ctrl.reg_write = 1'b0;
        end
    end

    // an empty slot reads r0, which never hazards
    assign id_rs      = if_valid ? if_instr.i.rs : '0;
    assign id_rt      = if_valid ? if_instr.i.rt : '0;
    assign id_uses_rt = rt_read;
    assign id_branch  = if_valid & is_beq;

    assign target   = if_pc + 32'd4 + {imm_ext[29:0], 2'b00};
    assign redirect = id_branch & ~stall & (rs_data == rt_data);

    always_ff @(posedge clk) begin
        id_ex.rs         <= if_instr.i.rs;
        // rt index kept only when rt is a source, so forwarding skips it otherwise
        id_ex.rt         <= rt_read ? if_instr.i.rt : '0;
        id_ex.dest       <= dest;
        id_ex.operand_a  <= rs_data;
        id_ex.operand_b  <= use_imm ? imm_ext : rt_data;
        id_ex.store_data <= rt_data;

        if (!rst_n || !run || stall || !if_valid) begin
            id_ex.ctrl <= '0;
        end else begin
            id_ex.ctrl <= dec_ctrl;
        end
    end

endmodule

`default_nettype wire

// ==== design/hazard_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  reg_idx_t id_rs,
    input  reg_idx_t id_rt,
    input  logic     id_branch,
    input  logic     id_uses_rt,
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    input  mem_wb_t  mem_wb,
    output logic     stall,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b,
    output fwd_sel_e fwd_store
);

    logic ex_writes;
    logic mem_writes;
    logic ex_hit;
    logic mem_hit;
    logic load_use;
    logic branch_wait;

    function automatic fwd_sel_e source(reg_idx_t idx, ex_mem_t m, mem_wb_t w);
        if (idx == '0) begin
            return fwd_none;
        end
        if (m.ctrl.valid && m.ctrl.reg_write && m.dest == idx) begin
            return fwd_mem;
        end
        if (w.valid && w.reg_write && w.dest == idx) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign ex_writes  = id_ex.ctrl.valid & id_ex.ctrl.reg_write;
    assign mem_writes = ex_mem.ctrl.valid & ex_mem.ctrl.reg_write;

    assign ex_hit  = (id_ex.dest != '0) &
                     ((id_ex.dest == id_rs) | (id_uses_rt & (id_ex.dest == id_rt)));
    assign mem_hit = (ex_mem.dest != '0) &
                     ((ex_mem.dest == id_rs) | (id_uses_rt & (ex_mem.dest == id_rt)));

    assign load_use = ex_writes & id_ex.ctrl.mem_read & ex_hit;

    // the branch compare only sees the register file, so it waits until WB
    assign branch_wait = id_branch & ((ex_writes & ex_hit) | (mem_writes & mem_hit));

    assign stall = load_use | branch_wait;

    // stores take an immediate on operand b, rt goes to store data
    assign fwd_a     = source(id_ex.rs, ex_mem, mem_wb);
    assign fwd_b     = id_ex.ctrl.mem_write ? fwd_none : source(id_ex.rt, ex_mem, mem_wb);
    assign fwd_store = id_ex.ctrl.mem_write ? source(id_ex.rt, ex_mem, mem_wb) : fwd_none;

endmodule

`default_nettype wire

// ==== design/execute_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_unit import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     run,
    input  id_ex_t   id_ex,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  fwd_sel_e fwd_store,
    input  word_t    wb_data,
    output ex_mem_t  ex_mem
);

    word_t op_a;
    word_t op_b;
    word_t st_data;
    word_t result;

    function automatic word_t pick(fwd_sel_e sel, word_t held, word_t mem_val, word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return held;
        endcase
    endfunction

    assign op_a    = pick(fwd_a, id_ex.operand_a, ex_mem.alu_result, wb_data);
    assign op_b    = pick(fwd_b, id_ex.operand_b, ex_mem.alu_result, wb_data);
    assign st_data = pick(fwd_store, id_ex.store_data, ex_mem.alu_result, wb_data);

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_sub: result = op_a - op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            alu_slt: result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            default: result = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        ex_mem.dest       <= id_ex.dest;
        ex_mem.alu_result <= result;
        ex_mem.store_data <= st_data;

        if (!rst_n || !run) begin
            ex_mem.ctrl <= '0;
        end else begin
            ex_mem.ctrl <= id_ex.ctrl;
        end
    end

endmodule

`default_nettype wire

// ==== design/memory_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module memory_unit import cpu_pkg::*; #(
    parameter int DMEM_ADDR_W = 8
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run,
    input  ex_mem_t   ex_mem,
    output mem_wb_t   mem_wb,
    output logic      wb_write,
    output reg_idx_t  wb_idx,
    output word_t     wb_data,
    output wb_trace_t trace
);

    word_t dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] addr;
    word_t read_data;

    // word addressed, byte offset dropped
    assign addr      = ex_mem.alu_result[DMEM_ADDR_W+1:2];
    assign read_data = dmem[addr];

    always_ff @(posedge clk) begin
        if (run && ex_mem.ctrl.valid && ex_mem.ctrl.mem_write) begin
            dmem[addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb.dest       <= ex_mem.dest;
        mem_wb.alu_result <= ex_mem.alu_result;
        mem_wb.read_data  <= read_data;

        if (!rst_n || !run) begin
            mem_wb.valid     <= 1'b0;
            mem_wb.reg_write <= 1'b0;
            mem_wb.mem_read  <= 1'b0;
        end else begin
            mem_wb.valid     <= ex_mem.ctrl.valid;
            mem_wb.reg_write <= ex_mem.ctrl.reg_write;
            mem_wb.mem_read  <= ex_mem.ctrl.mem_read;
        end
    end

    assign wb_write = mem_wb.valid & mem_wb.reg_write;
    assign wb_idx   = mem_wb.dest;
    assign wb_data  = mem_wb.mem_read ? mem_wb.read_data : mem_wb.alu_result;

    assign trace = '{valid: wb_write, idx: wb_idx, data: wb_data};

endmodule

`default_nettype wire

// ==== design/cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int IMEM_ADDR_W = 10,
    parameter int DMEM_ADDR_W = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    input  prog_write_t prog,
    output wb_trace_t   trace
);

    // fetch to decode
    word_t    if_pc;
    instr_u   if_instr;
    logic     if_valid;
    logic     redirect;
    word_t    target;

    // decode to hazard detection
    reg_idx_t id_rs;
    reg_idx_t id_rt;
    logic     id_branch;
    logic     id_uses_rt;
    logic     stall;

    // pipeline registers
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;

    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    fwd_sel_e fwd_store;

    logic     wb_write;
    reg_idx_t wb_idx;
    word_t    wb_data;

    fetch_unit #(
        .IMEM_ADDR_W(IMEM_ADDR_W)
    ) u_fetch (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .prog    (prog),
        .stall   (stall),
        .redirect(redirect),
        .target  (target),
        .if_pc   (if_pc),
        .if_instr(if_instr),
        .if_valid(if_valid)
    );

    decode_unit u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .stall     (stall),
        .if_pc     (if_pc),
        .if_instr  (if_instr),
        .if_valid  (if_valid),
        .wb_write  (wb_write),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data),
        .id_rs     (id_rs),
        .id_rt     (id_rt),
        .id_branch (id_branch),
        .id_uses_rt(id_uses_rt),
        .redirect  (redirect),
        .target    (target),
        .id_ex     (id_ex)
    );

    hazard_unit u_hazard (
        .id_rs     (id_rs),
        .id_rt     (id_rt),
        .id_branch (id_branch),
        .id_uses_rt(id_uses_rt),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb),
        .stall     (stall),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .fwd_store (fwd_store)
    );

    execute_unit u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .id_ex    (id_ex),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .fwd_store(fwd_store),
        .wb_data  (wb_data),
        .ex_mem   (ex_mem)
    );

    memory_unit #(
        .DMEM_ADDR_W(DMEM_ADDR_W)
    ) u_memory (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .ex_mem  (ex_mem),
        .mem_wb  (mem_wb),
        .wb_write(wb_write),
        .wb_idx  (wb_idx),
        .wb_data (wb_data),
        .trace   (trace)
    );

endmodule

`default_nettype wire

// ==== bench/cpu_cases.svh ====
`ifndef CPU_CASES_SVH
`define CPU_CASES_SVH

// one program per case, in word order; with_wb adds the write-back the word must retire
task automatic build_cases();
    logic [15:0] imm_a;
    logic [15:0] imm_b;
    word_t       va;
    word_t       vb;

    // alu chain, every step reads the result just before it
    open_case(0);
    with_wb(itype_word(op_addi, 5'd1, 5'd0, 16'd7), 5'd1, 32'd7);
    with_wb(itype_word(op_addi, 5'd2, 5'd1, 16'd5), 5'd2, 32'd12);
    with_wb(rtype_word(fn_add, 5'd3, 5'd2, 5'd1), 5'd3, 32'd19);
    with_wb(rtype_word(fn_sub, 5'd4, 5'd3, 5'd2), 5'd4, 32'd7);
    with_wb(rtype_word(fn_and, 5'd5, 5'd4, 5'd3), 5'd5, 32'd3);
    with_wb(rtype_word(fn_or, 5'd6, 5'd5, 5'd2), 5'd6, 32'd15);
    with_wb(rtype_word(fn_slt, 5'd7, 5'd5, 5'd6), 5'd7, 32'd1);
    with_wb(rtype_word(fn_slt, 5'd8, 5'd6, 5'd5), 5'd8, 32'd0);

    // negative immediates and signed compare
    open_case(1);
    with_wb(itype_word(op_addi, 5'd1, 5'd0, 16'hfffd), 5'd1, 32'hfffffffd);
    with_wb(itype_word(op_addi, 5'd2, 5'd1, 16'hfffb), 5'd2, 32'hfffffff8);
    with_wb(rtype_word(fn_slt, 5'd3, 5'd2, 5'd1), 5'd3, 32'd1);
    with_wb(rtype_word(fn_slt, 5'd4, 5'd1, 5'd0), 5'd4, 32'd1);
    with_wb(rtype_word(fn_slt, 5'd5, 5'd0, 5'd2), 5'd5, 32'd0);
    with_wb(itype_word(op_addi, 5'd6, 5'd0, 16'h7fff), 5'd6, 32'h00007fff);
    with_wb(rtype_word(fn_slt, 5'd7, 5'd6, 5'd1), 5'd7, 32'd0);

    // store then load back, loaded value used right away
    open_case(2);
    with_wb(itype_word(op_addi, 5'd1, 5'd0, 16'h1234), 5'd1, 32'h1234);
    put_instr(itype_word(op_sw, 5'd1, 5'd0, 16'd8));
    with_wb(itype_word(op_lw, 5'd2, 5'd0, 16'd8), 5'd2, 32'h1234);
    with_wb(rtype_word(fn_add, 5'd3, 5'd2, 5'd2), 5'd3, 32'h2468);
    with_wb(itype_word(op_addi, 5'd4, 5'd0, 16'd16), 5'd4, 32'd16);
    put_instr(itype_word(op_sw, 5'd3, 5'd4, 16'd4));
    with_wb(itype_word(op_lw, 5'd5, 5'd0, 16'd20), 5'd5, 32'h2468);
    with_wb(rtype_word(fn_sub, 5'd6, 5'd5, 5'd1), 5'd6, 32'h1234);

    // taken, not taken, and a branch on a value still in flight
    open_case(3);
    with_wb(itype_word(op_addi, 5'd1, 5'd0, 16'd1), 5'd1, 32'd1);
    with_wb(itype_word(op_addi, 5'd2, 5'd0, 16'd1), 5'd2, 32'd1);
    put_instr(itype_word(op_beq, 5'd2, 5'd1, 16'd1));
    put_instr(itype_word(op_addi, 5'd3, 5'd0, 16'h55));
    with_wb(itype_word(op_addi, 5'd4, 5'd0, 16'd2), 5'd4, 32'd2);
    put_instr(itype_word(op_beq, 5'd1, 5'd4, 16'd1));
    with_wb(itype_word(op_addi, 5'd5, 5'd0, 16'd3), 5'd5, 32'd3);
    with_wb(itype_word(op_addi, 5'd6, 5'd0, 16'd4), 5'd6, 32'd4);
    put_instr(itype_word(op_beq, 5'd0, 5'd0, 16'd1));
    put_instr(itype_word(op_addi, 5'd7, 5'd0, 16'h66));
    with_wb(itype_word(op_addi, 5'd7, 5'd0, 16'd9), 5'd7, 32'd9);

    // r0 as destination and as source
    open_case(4);
    put_instr(itype_word(op_addi, 5'd0, 5'd0, 16'h77));
    with_wb(itype_word(op_addi, 5'd1, 5'd0, 16'h21), 5'd1, 32'h21);
    put_instr(rtype_word(fn_add, 5'd0, 5'd1, 5'd1));
    with_wb(rtype_word(fn_add, 5'd2, 5'd0, 5'd1), 5'd2, 32'h21);
    with_wb(rtype_word(fn_or, 5'd3, 5'd0, 5'd0), 5'd3, 32'd0);
    with_wb(rtype_word(fn_sub, 5'd4, 5'd0, 5'd1), 5'd4, 32'hffffffdf);

    // random operands
    imm_a = 16'($random(seed));
    imm_b = 16'($random(seed));
    va    = sext16(imm_a);
    vb    = sext16(imm_b);
    open_case(5);
    with_wb(itype_word(op_addi, 5'd11, 5'd0, imm_a), 5'd11, va);
    with_wb(itype_word(op_addi, 5'd12, 5'd0, imm_b), 5'd12, vb);
    with_wb(rtype_word(fn_add, 5'd13, 5'd11, 5'd12), 5'd13, va + vb);
    with_wb(rtype_word(fn_sub, 5'd14, 5'd11, 5'd12), 5'd14, va - vb);
    with_wb(rtype_word(fn_slt, 5'd15, 5'd11, 5'd12), 5'd15,
            {31'd0, $signed(va) < $signed(vb)});
    with_wb(rtype_word(fn_and, 5'd16, 5'd12, 5'd11), 5'd16, va & vb);
    with_wb(rtype_word(fn_or, 5'd17, 5'd13, 5'd14), 5'd17, (va + vb) | (va - vb));

    // short reload, older words behind it must stay dead
    open_case(6);
    with_wb(itype_word(op_addi, 5'd9, 5'd0, 16'h3c), 5'd9, 32'h3c);
    with_wb(itype_word(op_addi, 5'd10, 5'd9, 16'd1), 5'd10, 32'h3d);
endtask

`endif

// ==== bench/cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int IMEM_ADDR_W    = 10;
    localparam int DMEM_ADDR_W    = 8;
    localparam int NUM_CASES      = 7;
    localparam int MAX_WORDS      = 16;
    localparam int QUIET_CYCLES   = 20;
    // loading and running each case, plus the reset cycles
    localparam int TIMEOUT_CYCLES = NUM_CASES * (MAX_WORDS + 40) + 16;

    logic        clk;
    logic        rst_n;
    logic        run;
    prog_write_t prog;
    wb_trace_t   trace;

    word_t     prog_mem [NUM_CASES][MAX_WORDS];
    int        prog_len [NUM_CASES];
    wb_trace_t exp_ev   [NUM_CASES][MAX_WORDS];
    int        exp_len  [NUM_CASES];
    int        cur_case;
    int        cycles;
    int        seed;

    cpu_top #(
        .IMEM_ADDR_W(IMEM_ADDR_W),
        .DMEM_ADDR_W(DMEM_ADDR_W)
    ) dut (
        .clk  (clk),
        .rst_n(rst_n),
        .run  (run),
        .prog (prog),
        .trace(trace)
    );

    always #10 clk = ~clk;

    function automatic word_t rtype_word(funct_e fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        return {op_rtype, rs, rt, rd, 5'd0, fn};
    endfunction

    // operand order follows assembly with the destination or data register first
    function automatic word_t itype_word(opcode_e op, reg_idx_t rt, reg_idx_t rs,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t sext16(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic open_case(input int n);
        cur_case    = n;
        prog_len[n] = 0;
        exp_len[n]  = 0;
    endtask

    task automatic put_instr(input word_t w);
        prog_mem[cur_case][prog_len[cur_case]] = w;
        prog_len[cur_case]++;
    endtask

    task automatic with_wb(input word_t w, input reg_idx_t idx, input word_t data);
        wb_trace_t ev;
        ev.valid = 1'b1;
        ev.idx   = idx;
        ev.data  = data;
        put_instr(w);
        exp_ev[cur_case][exp_len[cur_case]] = ev;
        exp_len[cur_case]++;
    endtask

    `include "cpu_cases.svh"

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_trace(input wb_trace_t got, input wb_trace_t exp,
                               input int case_no, input int ev_no);
        if (got.idx !== exp.idx) begin
            abort_run($sformatf("error: case %0d event %0d trace.idx got %h expected %h",
                                case_no, ev_no, got.idx, exp.idx));
        end else if (got.data !== exp.data) begin
            abort_run($sformatf("error: case %0d event %0d trace.data got %h expected %h",
                                case_no, ev_no, got.data, exp.data));
        end
    endtask

    // core held while loading and parked at the end by a branch to itself
    task automatic load_program(input int c);
        for (int k = 0; k <= prog_len[c]; k++) begin
            @(negedge clk);
            run       = 1'b0;
            prog.we   = 1'b1;
            prog.addr = 10'(k);
            if (k < prog_len[c]) begin
                prog.data = prog_mem[c][k];
            end else begin
                prog.data = itype_word(op_beq, 5'd0, 5'd0, 16'hffff);
            end
        end
        @(negedge clk);
        prog.we = 1'b0;
        run     = 1'b1;
    endtask

    task automatic collect_events(input int c);
        int seen;
        seen = 0;
        while (seen < exp_len[c]) begin
            @(negedge clk);
            if (trace.valid === 1'b1) begin
                check_trace(trace, exp_ev[c][seen], c, seen);
                seen++;
            end
        end
    endtask

    task automatic wait_quiet(input int c);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (trace.valid !== 1'b0) begin
                abort_run($sformatf("case %0d wrote r%0d after all %0d expected write-backs",
                                    c, trace.idx, exp_len[c]));
            end
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            abort_run($sformatf("run did not complete within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        run    = 1'b0;
        prog   = '0;
        cycles = 0;
        seed   = 32'h0db88135;
        build_cases();

        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        for (int c = 0; c < NUM_CASES; c++) begin
            load_program(c);
            collect_events(c);
            wait_quiet(c);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+bench
design/cpu_pkg.sv
design/register_file.sv
design/fetch_unit.sv
design/decode_unit.sv
design/hazard_unit.sv
design/execute_unit.sv
design/memory_unit.sv
design/cpu_top.sv
bench/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - design/cpu_pkg.sv
  - design/register_file.sv
  - design/fetch_unit.sv
  - design/decode_unit.sv
  - design/hazard_unit.sv
  - design/execute_unit.sv
  - design/memory_unit.sv
  - design/cpu_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/cpu_tb.sv
